// File: rtl/riscv_isa_pkg.sv
package riscv_isa_pkg;

  // register, address and instruction width
  localparam int unsigned xlen = 32;
  localparam int unsigned reg_idx_w = 5;
  localparam int unsigned num_regs = 32;

  // instruction field widths
  localparam int unsigned opcode_w = 7;
  localparam int unsigned funct3_w = 3;
  localparam int unsigned funct7_w = 7;

  localparam logic [xlen-1:0] pc_step = 4;

  // selects sub over add and sra over srl
  localparam logic [funct7_w-1:0] funct7_alt = 7'b0100000;

  typedef enum logic [opcode_w-1:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  // 3'b010 and 3'b011 are not valid branch encodings
  typedef enum logic [funct3_w-1:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } branch_f3_e;

  typedef enum logic [funct3_w-1:0] {
    alu_add_sub = 3'b000,
    alu_sll     = 3'b001,
    alu_slt     = 3'b010,
    alu_sltu    = 3'b011,
    alu_xor     = 3'b100,
    alu_srl_sra = 3'b101,
    alu_or      = 3'b110,
    alu_and     = 3'b111
  } alu_f3_e;

endpackage

// File: rtl/pipeline_pkg.sv
package pipeline_pkg;

  import riscv_isa_pkg::*;

  // classifies each cycle as it reaches writeback
  // exactly one value holds for a given cycle
  typedef enum logic [xlen-1:0] {
    // never seen once the reset sequence is over
    cycle_invalid      = 0,
    // bubble left behind by reset
    cycle_reset        = 1,
    // a real instruction
    cycle_no_stall     = 2,
    // slot squashed by a taken branch or jump
    cycle_taken_branch = 4
  } cycle_status_e;

  // fetch/decode register contents
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] insn;
    cycle_status_e   status;
  } decode_rec_t;

  // decode/execute register contents, operands already read
  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [xlen-1:0] insn;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    cycle_status_e   status;
  } execute_rec_t;

endpackage

// File: rtl/writeback_if.sv
`timescale 1ns/1ns

interface writeback_if
  import riscv_isa_pkg::*, pipeline_pkg::*;
();

  logic [xlen-1:0]      pc;
  logic [xlen-1:0]      insn;
  cycle_status_e        status;
  // register file write port
  logic                 we;
  logic [reg_idx_w-1:0] rd;
  logic [xlen-1:0]      data;

  modport source (output pc, insn, status, we, rd, data);

  modport sink (input pc, insn, status, we, rd, data);

endinterface

// File: rtl/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
  import riscv_isa_pkg::*, pipeline_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  logic            redirect,
  input  logic [xlen-1:0] redirect_pc,
  input  logic [xlen-1:0] insn_from_imem,
  output logic [xlen-1:0] pc_to_imem,
  output decode_rec_t     decode_rec
);

  logic [xlen-1:0] pc;

  // program counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + pc_step;
    end
  end

  assign pc_to_imem = pc;

  // fetch/decode register
  // the word fetched while a redirect is pending is on the wrong path
  always_ff @(posedge clk) begin
    if (rst) begin
      decode_rec <= '{pc: '0, insn: '0, status: cycle_reset};
    end else if (redirect) begin
      decode_rec <= '{pc: '0, insn: '0, status: cycle_taken_branch};
    end else begin
      decode_rec <= '{pc: pc, insn: insn_from_imem, status: cycle_no_stall};
    end
  end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ns

module decode_stage
  import riscv_isa_pkg::*, pipeline_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         redirect,
  input  decode_rec_t  decode_rec,
  writeback_if.sink    wb,
  output execute_rec_t execute_rec
);

  logic [xlen-1:0]      regs [num_regs];
  logic [reg_idx_w-1:0] rs1;
  logic [reg_idx_w-1:0] rs2;
  logic [xlen-1:0]      rs1_data;
  logic [xlen-1:0]      rs2_data;

  assign rs1 = decode_rec.insn[19:15];
  assign rs2 = decode_rec.insn[24:20];

  // register file, written from the writeback record
  // we is never high for x0, so x0 keeps its reset value
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.we) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // read ports, bypassing the value being written this cycle
  always_comb begin
    if (wb.we && wb.rd == rs1) begin
      rs1_data = wb.data;
    end else if (rs1 == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1];
    end
  end

  always_comb begin
    if (wb.we && wb.rd == rs2) begin
      rs2_data = wb.data;
    end else if (rs2 == '0) begin
      rs2_data = '0;
    end else begin
      rs2_data = regs[rs2];
    end
  end

  // decode/execute register
  always_ff @(posedge clk) begin
    if (rst) begin
      execute_rec <= '{pc: '0, insn: '0, a: '0, b: '0, status: cycle_reset};
    end else if (redirect) begin
      // younger than the branch in execute, squash it
      execute_rec <= '{pc: '0, insn: '0, a: '0, b: '0, status: cycle_taken_branch};
    end else begin
      execute_rec <= '{
        pc:     decode_rec.pc,
        insn:   decode_rec.insn,
        a:      rs1_data,
        b:      rs2_data,
        status: decode_rec.status
      };
    end
  end

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ns

module execute_stage
  import riscv_isa_pkg::*, pipeline_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  input  execute_rec_t    execute_rec,
  output logic            redirect,
  output logic [xlen-1:0] redirect_pc,
  writeback_if.source     wb,
  output logic            halt
);

  opcode_e              opcode;
  alu_f3_e              alu_f3;
  branch_f3_e           br_f3;
  logic [reg_idx_w-1:0] rd;
  logic [reg_idx_w-1:0] rs1;
  logic [reg_idx_w-1:0] rs2;
  logic [funct7_w-1:0]  funct7;
  logic                 is_alt;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_j;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] alu_b;
  logic [4:0]      shamt;
  logic [xlen-1:0] alu_out;
  logic [xlen-1:0] link;
  logic [xlen-1:0] result;
  logic [xlen-1:0] target;
  logic            br_taken;
  logic            take;
  logic            writes_rd;
  logic            rd_we;
  logic            wb_ecall;
  logic            halt_q;

  // instruction fields
  assign opcode = opcode_e'(execute_rec.insn[6:0]);
  assign rd     = execute_rec.insn[11:7];
  assign alu_f3 = alu_f3_e'(execute_rec.insn[14:12]);
  assign br_f3  = branch_f3_e'(execute_rec.insn[14:12]);
  assign rs1    = execute_rec.insn[19:15];
  assign rs2    = execute_rec.insn[24:20];
  assign funct7 = execute_rec.insn[31:25];
  assign is_alt = (funct7 == funct7_alt);

  // the instruction one ahead is in writeback and its result was not yet
  // in the register file when these operands were read
  assign op_a = (wb.we && wb.rd == rs1) ? wb.data : execute_rec.a;
  assign op_b = (wb.we && wb.rd == rs2) ? wb.data : execute_rec.b;

  // immediates
  assign imm_i = {{20{execute_rec.insn[31]}}, execute_rec.insn[31:20]};
  assign imm_b = {{19{execute_rec.insn[31]}}, execute_rec.insn[31], execute_rec.insn[7],
                  execute_rec.insn[30:25], execute_rec.insn[11:8], 1'b0};
  assign imm_j = {{11{execute_rec.insn[31]}}, execute_rec.insn[31], execute_rec.insn[19:12],
                  execute_rec.insn[20], execute_rec.insn[30:21], 1'b0};
  assign imm_u = {execute_rec.insn[31:12], 12'b0};

  assign alu_b = (opcode == opc_op) ? op_b : imm_i;
  assign shamt = alu_b[4:0];
  assign link  = execute_rec.pc + pc_step;

  always_comb begin
    alu_out = '0;
    case (alu_f3)
      // sub only exists in register-register form
      alu_add_sub: begin
        if (opcode == opc_op && is_alt) begin
          alu_out = op_a - alu_b;
        end else begin
          alu_out = op_a + alu_b;
        end
      end
      alu_sll:  alu_out = op_a << shamt;
      alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
      alu_sltu: alu_out = {{(xlen-1){1'b0}}, op_a < alu_b};
      alu_xor:  alu_out = op_a ^ alu_b;
      alu_srl_sra: begin
        if (is_alt) begin
          alu_out = $signed(op_a) >>> shamt;
        end else begin
          alu_out = op_a >> shamt;
        end
      end
      alu_or:   alu_out = op_a | alu_b;
      alu_and:  alu_out = op_a & alu_b;
      default:  alu_out = '0;
    endcase
  end

  always_comb begin
    case (br_f3)
      br_beq:  br_taken = (op_a == op_b);
      br_bne:  br_taken = (op_a != op_b);
      br_blt:  br_taken = ($signed(op_a) < $signed(op_b));
      br_bge:  br_taken = ($signed(op_a) >= $signed(op_b));
      br_bltu: br_taken = (op_a < op_b);
      br_bgeu: br_taken = (op_a >= op_b);
      default: br_taken = 1'b0;
    endcase
  end

  // result select and control flow
  // anything outside the kept opcodes falls through as a no-op
  always_comb begin
    result    = '0;
    writes_rd = 1'b0;
    take      = 1'b0;
    target    = '0;
    case (opcode)
      opc_lui: begin
        result    = imm_u;
        writes_rd = 1'b1;
      end
      opc_auipc: begin
        result    = execute_rec.pc + imm_u;
        writes_rd = 1'b1;
      end
      opc_jal: begin
        result    = link;
        writes_rd = 1'b1;
        take      = 1'b1;
        target    = execute_rec.pc + imm_j;
      end
      opc_jalr: begin
        result    = link;
        writes_rd = 1'b1;
        take      = 1'b1;
        target    = (op_a + imm_i) & {{(xlen-1){1'b1}}, 1'b0};
      end
      opc_branch: begin
        take   = br_taken;
        target = execute_rec.pc + imm_b;
      end
      opc_op_imm, opc_op: begin
        result    = alu_out;
        writes_rd = 1'b1;
      end
      default: begin
        result = '0;
      end
    endcase
  end

  // bubbles never redirect or write
  assign redirect    = take && execute_rec.status == cycle_no_stall;
  assign redirect_pc = target;
  assign rd_we       = writes_rd && rd != '0 && execute_rec.status == cycle_no_stall;

  // writeback register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb.pc     <= '0;
      wb.insn   <= '0;
      wb.status <= cycle_reset;
      wb.we     <= 1'b0;
      wb.rd     <= '0;
      wb.data   <= '0;
    end else begin
      wb.pc     <= execute_rec.pc;
      wb.insn   <= execute_rec.insn;
      wb.status <= execute_rec.status;
      wb.we     <= rd_we;
      wb.rd     <= rd;
      wb.data   <= rd_we ? result : '0;
    end
  end

  // ecall in writeback raises halt in the same cycle, halt_q holds it
  assign wb_ecall = wb.status == cycle_no_stall && wb.insn[6:0] == opc_system
                    && wb.insn[31:7] == '0;
  assign halt     = halt_q | wb_ecall;

  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
    end else begin
      halt_q <= halt;
    end
  end

endmodule

// File: rtl/rv_pipeline_top.sv
`timescale 1ns/1ns

module rv_pipeline_top
  import riscv_isa_pkg::*, pipeline_pkg::*;
(
  input  logic            clk,
  input  logic            rst,
  // instruction memory, answers in the same cycle
  output logic [xlen-1:0] pc_to_imem,
  input  logic [xlen-1:0] insn_from_imem,
  // writeback trace
  output logic [xlen-1:0] trace_pc,
  output logic [xlen-1:0] trace_insn,
  output cycle_status_e   trace_cycle_status,
  output logic [xlen-1:0] trace_rd_data,
  output logic            halt
);

  decode_rec_t     decode_rec;
  execute_rec_t    execute_rec;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;

  writeback_if wb ();

  fetch_stage u_fetch (
    .clk            (clk),
    .rst            (rst),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .decode_rec     (decode_rec)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .decode_rec  (decode_rec),
    .wb          (wb),
    .execute_rec (execute_rec)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst         (rst),
    .execute_rec (execute_rec),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .wb          (wb),
    .halt        (halt)
  );

  // data is already zero when the record does not write rd
  assign trace_pc           = wb.pc;
  assign trace_insn         = wb.insn;
  assign trace_cycle_status = wb.status;
  assign trace_rd_data      = wb.data;

endmodule

// File: tests/rv_pipeline_properties.sv
`timescale 1ns/1ns

module rv_pipeline_properties
  import pipeline_pkg::*;
(
  input logic          clk,
  input logic          rst,
  input cycle_status_e trace_cycle_status,
  input logic          halt
);

  logic is_squash;

  assign is_squash = trace_cycle_status == cycle_taken_branch;

  // only reset clears halt
  a_halt_sticky: assert property (
    @(posedge clk) disable iff (rst) halt |=> halt
  ) else $error("halt fell without reset");

  // a redirect squashes exactly the two younger slots
  a_squash_pair: assert property (
    @(posedge clk) disable iff (rst) $rose(is_squash) |=> is_squash ##1 !is_squash
  ) else $error("taken_branch run is not two cycles long");

  a_status_valid: assert property (
    @(posedge clk) disable iff (rst) trace_cycle_status != cycle_invalid
  ) else $error("trace status is invalid");

endmodule

bind rv_pipeline_top rv_pipeline_properties props (
  .clk                (clk),
  .rst                (rst),
  .trace_cycle_status (trace_cycle_status),
  .halt               (halt)
);

// File: tests/rv_pipeline_tb.sv
`timescale 1ns/1ns

module rv_pipeline_tb
  import riscv_isa_pkg::*, pipeline_pkg::*;
();

  localparam int prog_len = 64;
  localparam int mem_words = 128;
  localparam int timeout_cycles = 4 * prog_len + 20;
  localparam logic [31:0] seed = 32'd90074;
  localparam logic [31:0] ecall_insn = 32'h0000_0073;

  logic          clk;
  logic          rst;
  logic [31:0]   pc_to_imem;
  logic [31:0]   insn_from_imem;
  logic [31:0]   trace_pc;
  logic [31:0]   trace_insn;
  cycle_status_e trace_cycle_status;
  logic [31:0]   trace_rd_data;
  logic          halt;

  logic [31:0] imem [mem_words];
  logic [31:0] lfsr_state;
  int          error_count;

  // expected retirement order from the reference model
  logic [31:0] exp_pc [prog_len];
  logic [31:0] exp_insn [prog_len];
  logic [31:0] exp_data [prog_len];
  logic        exp_taken [prog_len];
  int          exp_count;

  rv_pipeline_top dut (
    .clk                (clk),
    .rst                (rst),
    .pc_to_imem         (pc_to_imem),
    .insn_from_imem     (insn_from_imem),
    .trace_pc           (trace_pc),
    .trace_insn         (trace_insn),
    .trace_cycle_status (trace_cycle_status),
    .trace_rd_data      (trace_rd_data),
    .halt               (halt)
  );

  initial begin
    clk = 1'b0;
  end

  always #4 clk = ~clk;

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    // anything past the array reads as ecall padding
    if (addr[31:9] != '0) begin
      return ecall_insn;
    end
    return imem[addr[8:2]];
  endfunction

  function automatic logic [31:0] imm_i(input logic [31:0] insn);
    return {{20{insn[31]}}, insn[31:20]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] insn);
    return {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] insn);
    return {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      alu_add_sub: r = alt ? a - b : a + b;
      alu_sll:     r = a << b[4:0];
      alu_slt:     r = {31'b0, $signed(a) < $signed(b)};
      alu_sltu:    r = {31'b0, a < b};
      alu_xor:     r = a ^ b;
      alu_srl_sra: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      alu_or:      r = a | b;
      default:     r = a & b;
    endcase
    return r;
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
    case (f3)
      br_beq:  return a == b;
      br_bne:  return a != b;
      br_blt:  return $signed(a) < $signed(b);
      br_bge:  return $signed(a) >= $signed(b);
      br_bltu: return a < b;
      br_bgeu: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      error_count++;
      $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, expected);
      $display("Regression failed");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("error at t=%0t: %s", $time, what);
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  // random kinds use x0..x7, control flow only jumps forward
  task automatic build_program();
    logic [31:0] insn;
    logic [31:0] off;
    logic [31:0] tgt;
    logic [19:0] imm20;
    logic [11:0] imm12;
    logic [6:0]  f7;
    logic [4:0]  sh;
    logic [3:0]  kind;
    logic [2:0]  rd;
    logic [2:0]  rs1;
    logic [2:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    int          k;
    for (int i = 0; i < mem_words; i++) begin
      imem[i] = ecall_insn;
    end
    for (int i = 0; i < prog_len - 1; i++) begin
      kind = rand_bits(4);
      rd = rand_bits(3);
      rs1 = rand_bits(3);
      rs2 = rand_bits(3);
      f3 = rand_bits(3);
      alt = rand_bits(1);
      imm20 = rand_bits(20);
      imm12 = rand_bits(12);
      sh = rand_bits(5);
      k = 1 + rand_bits(3);
      if (k > prog_len - 1 - i) begin
        k = prog_len - 1 - i;
      end
      off = k * 4;
      case (kind)
        4'd0: insn = {imm20, 2'b00, rd, opc_lui};
        4'd1: insn = {imm20, 2'b00, rd, opc_auipc};
        4'd2, 4'd3, 4'd4, 4'd5: begin
          if (f3 == alu_sll) begin
            imm12 = {7'b0, sh};
          end else if (f3 == alu_srl_sra) begin
            imm12 = {alt ? funct7_alt : 7'b0, sh};
          end
          insn = {imm12, 2'b00, rs1, f3, 2'b00, rd, opc_op_imm};
        end
        4'd6, 4'd7, 4'd8, 4'd9: begin
          f7 = (alt && (f3 == alu_add_sub || f3 == alu_srl_sra)) ? funct7_alt : 7'b0;
          insn = {f7, 2'b00, rs2, 2'b00, rs1, f3, 2'b00, rd, opc_op};
        end
        4'd10, 4'd11, 4'd12: begin
          // 010 and 011 are not branches, fold them onto blt and bge
          if (f3 == 3'b010 || f3 == 3'b011) begin
            f3 = f3 ^ 3'b110;
          end
          insn = {off[12], off[10:5], 2'b00, rs2, 2'b00, rs1, f3, off[4:1], off[11],
                  opc_branch};
        end
        4'd13: insn = {off[20], off[10:1], off[11], off[19:12], 2'b00, rd, opc_jal};
        4'd14: begin
          // jalr from x0, so the immediate is the absolute target
          tgt = i * 4 + off;
          insn = {tgt[11:0], 5'b0, 3'b000, 2'b00, rd, opc_jalr};
        end
        default: insn = {imm12, 2'b00, rs1, 3'b000, 2'b00, rd, opc_op_imm};
      endcase
      imem[i] = insn;
    end
  endtask

  // sequential ISA-level execution until ecall
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] pc;
    logic [31:0] insn;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] next;
    logic        wr;
    logic        taken;
    logic        stop;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = '0;
    stop = 1'b0;
    exp_count = 0;
    while (!stop) begin
      insn = imem[pc[8:2]];
      a = regs[insn[19:15]];
      b = regs[insn[24:20]];
      val = '0;
      wr = 1'b0;
      taken = 1'b0;
      next = pc + 4;
      case (insn[6:0])
        opc_lui: begin
          val = {insn[31:12], 12'b0};
          wr = 1'b1;
        end
        opc_auipc: begin
          val = pc + {insn[31:12], 12'b0};
          wr = 1'b1;
        end
        opc_jal: begin
          val = pc + 4;
          wr = 1'b1;
          taken = 1'b1;
          next = pc + imm_j(insn);
        end
        opc_jalr: begin
          val = pc + 4;
          wr = 1'b1;
          taken = 1'b1;
          next = (a + imm_i(insn)) & ~32'd1;
        end
        opc_branch: begin
          taken = branch_taken(insn[14:12], a, b);
          if (taken) begin
            next = pc + imm_b(insn);
          end
        end
        opc_op_imm: begin
          val = alu_model(insn[14:12], insn[30] && insn[14:12] == alu_srl_sra, a, imm_i(insn));
          wr = 1'b1;
        end
        opc_op: begin
          val = alu_model(insn[14:12], insn[30], a, b);
          wr = 1'b1;
        end
        default: stop = 1'b1;
      endcase
      if (wr && insn[11:7] != 5'd0) begin
        regs[insn[11:7]] = val;
      end else begin
        val = '0;
      end
      exp_pc[exp_count] = pc;
      exp_insn[exp_count] = insn;
      exp_data[exp_count] = val;
      exp_taken[exp_count] = taken;
      exp_count++;
      pc = next;
    end
  endtask

  // instruction memory, follows pc_to_imem within the cycle
  always @(posedge clk) begin
    #1;
    insn_from_imem = fetch_word(pc_to_imem);
  end

  initial begin
    wait (rst === 1'b0);
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: halt never came within %0d cycles", timeout_cycles);
    $display("Regression failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    int   idx;
    int   squash_left;
    logic done;
    logic is_ecall;
    rst = 1'b1;
    insn_from_imem = '0;
    error_count = 0;
    lfsr_state = seed;
    build_program();
    run_model();
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    // reset bubbles still draining
    for (int i = 0; i < 3; i++) begin
      @(negedge clk);
      if (i == 0) begin
        check_value("pc_to_imem", pc_to_imem, 32'd0);
      end
      check_value("trace_cycle_status", trace_cycle_status, cycle_reset);
      check_value("trace_pc", trace_pc, 32'd0);
      check_value("trace_insn", trace_insn, 32'd0);
      check_value("trace_rd_data", trace_rd_data, 32'd0);
      check_value("halt", halt, 32'd0);
    end
    idx = 0;
    squash_left = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      if (squash_left > 0) begin
        check_value("trace_cycle_status", trace_cycle_status, cycle_taken_branch);
        check_value("halt", halt, 32'd0);
        squash_left--;
      end else begin
        check_value("trace_cycle_status", trace_cycle_status, cycle_no_stall);
        if (idx >= exp_count) begin
          report_error("trace retired an instruction the model never reached");
        end
        check_value("trace_pc", trace_pc, exp_pc[idx]);
        check_value("trace_insn", trace_insn, exp_insn[idx]);
        check_value("trace_rd_data", trace_rd_data, exp_data[idx]);
        is_ecall = exp_insn[idx] == ecall_insn;
        check_value("halt", halt, is_ecall);
        if (exp_taken[idx]) begin
          squash_left = 2;
        end
        if (is_ecall) begin
          done = 1'b1;
        end
        idx++;
      end
    end
    // halt holds while the padding drains
    repeat (3) begin
      @(negedge clk);
      check_value("halt", halt, 32'd1);
    end
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: sources.f
rtl/riscv_isa_pkg.sv
rtl/pipeline_pkg.sv
rtl/writeback_if.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/rv_pipeline_top.sv
tests/rv_pipeline_properties.sv
tests/rv_pipeline_tb.sv
